// ==== design/ctrl_pkg.sv ====
/*
  shared definitions of the core control unit
  - data widths and the vector typedefs built on them
  - exception and interrupt cause codes
  - privilege, pc source, exception pc and controller state enums
  - packed structs that travel between the controller blocks
*/
package ctrl_pkg;

  // data and address width
  localparam int XLEN         = 32;
  localparam int NUM_FAST_IRQ = 15;

  typedef logic [XLEN-1:0]         word_t;
  typedef logic [15:0]             half_t;
  typedef logic [NUM_FAST_IRQ-1:0] fast_irq_t;
  typedef logic [3:0]              fast_id_t;
  // bit 5 marks an interrupt, bits 4:0 hold the code
  typedef logic [5:0]              exc_cause_t;

  //////////////////////////////////////////////////////////////////////
  // cause codes
  //////////////////////////////////////////////////////////////////////

  // synchronous exceptions
  localparam exc_cause_t EXC_CAUSE_INSTR_ACCESS_FAULT = {1'b0, 5'd1};
  localparam exc_cause_t EXC_CAUSE_ILLEGAL_INSN       = {1'b0, 5'd2};
  localparam exc_cause_t EXC_CAUSE_BREAKPOINT         = {1'b0, 5'd3};
  localparam exc_cause_t EXC_CAUSE_ECALL_UMODE        = {1'b0, 5'd8};
  localparam exc_cause_t EXC_CAUSE_ECALL_MMODE        = {1'b0, 5'd11};

  // interrupts, machine level
  localparam exc_cause_t EXC_CAUSE_IRQ_SOFTWARE_M     = {1'b1, 5'd3};
  localparam exc_cause_t EXC_CAUSE_IRQ_TIMER_M        = {1'b1, 5'd7};
  localparam exc_cause_t EXC_CAUSE_IRQ_EXTERNAL_M     = {1'b1, 5'd11};
  localparam exc_cause_t EXC_CAUSE_IRQ_NM             = {1'b1, 5'd31};

  // fast line i maps to code 16 + i
  function automatic exc_cause_t fast_irq_cause(fast_id_t id);
    return {2'b11, id};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // enums
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // fetch address source of the IF stage
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  // handler base when pc_mux selects PC_EXC
  typedef enum logic {
    EXC_PC_IRQ,
    EXC_PC_EXC
  } exc_pc_sel_e;

  typedef enum logic [2:0] {
    RESET,
    BOOT_SET,
    WAIT_SLEEP,
    SLEEP,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // structs
  //////////////////////////////////////////////////////////////////////

  // raw decoder flags, not yet qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic mret;
    logic wfi;
    logic ebrk;
    logic csr_pipe_flush;
  } dec_flags_t;

  // instruction held in the IF-ID register
  typedef struct packed {
    logic  valid;
    word_t instr;
    half_t instr_c;
    logic  is_compressed;
    logic  fetch_err;
    logic  fetch_err_plus2;
    word_t pc;
  } instr_info_t;

  typedef struct packed {
    logic      software;
    logic      timer;
    logic      external;
    fast_irq_t fast;
  } irqs_t;

  typedef struct packed {
    logic special_req;
    logic branch_block;
    logic exc_req;
    logic mret;
    logic wfi;
    logic csr_flush;
  } special_t;

  typedef struct packed {
    exc_cause_t cause;
    word_t      mtval;
  } exc_info_t;

  typedef struct packed {
    logic       handle;
    logic       wake;
    logic       nmi;
    exc_cause_t cause;
  } irq_req_t;

  typedef struct packed {
    logic        pc_set;
    pc_sel_e     pc_mux;
    exc_pc_sel_e exc_pc_mux;
  } pc_ctrl_t;

  typedef struct packed {
    logic  save_if;
    logic  save_id;
    logic  save_cause;
    logic  restore_mret;
    word_t mtval;
  } csr_ctrl_t;

endpackage

// ==== design/exc_detect.sv ====
/*
  synchronous exception detection
  - qualifies the decoder flags with the valid bit
  - registered illegal flag and exception request, cleared in FLUSH
  - fixed priority cause selection with mtval
*/
module exc_detect import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dec_flags_t  dec_i,
  input  instr_info_t instr_i,
  input  priv_lvl_e   priv_i,
  input  logic        mstatus_tw_i,
  input  logic        in_flush_i,
  output special_t    special_o,
  output exc_info_t   exc_o
);

  logic ecall;
  logic mret;
  logic wfi;
  logic ebrk;
  logic csr_flush;
  logic fetch_err;
  logic illegal_umode;
  logic illegal_d;
  logic illegal_q;
  logic exc_req_d;
  logic exc_req_q;

  // decoder flags only count for a valid instruction
  assign ecall     = dec_i.ecall          & instr_i.valid;
  assign mret      = dec_i.mret           & instr_i.valid;
  assign wfi       = dec_i.wfi            & instr_i.valid;
  assign ebrk      = dec_i.ebrk           & instr_i.valid;
  assign csr_flush = dec_i.csr_pipe_flush & instr_i.valid;
  assign fetch_err = instr_i.fetch_err    & instr_i.valid;

  // mret needs M-mode, tw traps wfi outside M-mode
  assign illegal_umode = (priv_i != PRIV_LVL_M) & (mret | (mstatus_tw_i & wfi));

  // dropped in FLUSH so a handled fault does not fire twice
  assign illegal_d = ((dec_i.illegal & instr_i.valid) | illegal_umode) & ~in_flush_i;
  assign exc_req_d = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;

  assign special_o.special_req  = mret | wfi | csr_flush | exc_req_d;
  // only a fetch fault can collide with a branch
  assign special_o.branch_block = fetch_err & ~in_flush_i;
  assign special_o.exc_req      = exc_req_q;
  assign special_o.mret         = mret;
  assign special_o.wfi          = wfi;
  assign special_o.csr_flush    = csr_flush;

  //////////////////////////////////////////////////////////////////////
  // exception priority
  //////////////////////////////////////////////////////////////////////

  // instruction stays in ID through FLUSH, so the flags are still live
  always_comb begin
    exc_o.cause = '0;
    exc_o.mtval = '0;
    if (fetch_err) begin
      exc_o.cause = EXC_CAUSE_INSTR_ACCESS_FAULT;
      // fault in the upper half of an unaligned word
      exc_o.mtval = instr_i.fetch_err_plus2 ? (instr_i.pc + 32'd2) : instr_i.pc;
    end else if (illegal_q) begin
      exc_o.cause = EXC_CAUSE_ILLEGAL_INSN;
      exc_o.mtval = instr_i.is_compressed ? {{(XLEN-16){1'b0}}, instr_i.instr_c} :
                                            instr_i.instr;
    end else if (ecall) begin
      exc_o.cause = (priv_i == PRIV_LVL_M) ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ECALL_UMODE;
    end else if (ebrk) begin
      // no debug mode here, ebreak always traps
      exc_o.cause = EXC_CAUSE_BREAKPOINT;
    end
  end

  // breaks the path from the decoder into pc_set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q <= 1'b0;
      exc_req_q <= 1'b0;
    end else begin
      illegal_q <= illegal_d;
      exc_req_q <= exc_req_d;
    end
  end

endmodule

// ==== design/irq_select.sv ====
/*
  interrupt selection
  - decides whether an interrupt is taken and whether the core wakes
  - priority encoder over the fast lines
  - cause by priority: nmi, fast, external, software, timer
*/
module irq_select import ctrl_pkg::*; (
  input  irqs_t    irqs_i,
  input  logic     irq_nm_i,
  input  logic     mstatus_mie_i,
  input  logic     nmi_mode_i,
  output irq_req_t irq_o
);

  logic       irq_pending;
  logic       take_nmi;
  fast_id_t   fast_id;
  exc_cause_t irq_cause;

  // lines arrive already masked by mie
  assign irq_pending = irqs_i.software | irqs_i.timer | irqs_i.external | (|irqs_i.fast);

  // no nesting inside the nmi handler
  assign take_nmi = irq_nm_i & ~nmi_mode_i;

  //////////////////////////////////////////////////////////////////////
  // fast line encoder
  //////////////////////////////////////////////////////////////////////

  // later iterations overwrite, so the highest line wins
  always_comb begin
    fast_id = '0;
    for (int i = 0; i < NUM_FAST_IRQ; i++) begin
      if (irqs_i.fast[i]) begin
        fast_id = fast_id_t'(i);
      end
    end
  end

  always_comb begin
    if (take_nmi) begin
      irq_cause = EXC_CAUSE_IRQ_NM;
    end else if (|irqs_i.fast) begin
      irq_cause = fast_irq_cause(fast_id);
    end else if (irqs_i.external) begin
      irq_cause = EXC_CAUSE_IRQ_EXTERNAL_M;
    end else if (irqs_i.software) begin
      irq_cause = EXC_CAUSE_IRQ_SOFTWARE_M;
    end else begin
      // timer, or nothing pending
      irq_cause = EXC_CAUSE_IRQ_TIMER_M;
    end
  end

  // nmi ignores mie, regular lines need it
  assign irq_o.handle = ~nmi_mode_i & (irq_nm_i | (irq_pending & mstatus_mie_i));
  // sleep ends on any pending line, even with mie clear
  assign irq_o.wake   = irq_pending | irq_nm_i;
  assign irq_o.nmi    = take_nmi;
  assign irq_o.cause  = irq_cause;

endmodule

// ==== design/ctrl_fsm.sv ====
/*
  controller state machine
  - boot, decode, flush, sleep and interrupt entry states
  - pc source control and csr save strobes
  - nmi mode register
  - stall control towards the IF stage and perf strobes
*/
module ctrl_fsm import ctrl_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  special_t   special_i,
  input  exc_info_t  exc_i,
  input  irq_req_t   irq_i,
  input  logic       instr_valid_i,
  input  logic       branch_set_i,
  input  logic       jump_set_i,
  input  logic       stall_id_i,
  output logic       in_flush_o,
  output pc_ctrl_t   pc_ctrl_o,
  output exc_cause_t exc_cause_o,
  output csr_ctrl_t  csr_ctrl_o,
  output logic       id_in_ready_o,
  output logic       instr_valid_clear_o,
  output logic       flush_id_o,
  output logic       ctrl_busy_o,
  output logic       controller_run_o,
  output logic       nmi_mode_o,
  output logic       perf_jump_o,
  output logic       perf_tbranch_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        nmi_mode_q;
  logic        nmi_mode_d;

  logic stall;
  logic halt_if;
  logic retain_id;
  logic flush_id;

  // multicycle instruction still busy in ID
  assign stall = stall_id_i;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d    = state_q;
    nmi_mode_d = nmi_mode_q;

    pc_ctrl_o.pc_set     = 1'b0;
    pc_ctrl_o.pc_mux     = PC_BOOT;
    pc_ctrl_o.exc_pc_mux = EXC_PC_IRQ;
    exc_cause_o          = '0;

    csr_ctrl_o.save_if      = 1'b0;
    csr_ctrl_o.save_id      = 1'b0;
    csr_ctrl_o.save_cause   = 1'b0;
    csr_ctrl_o.restore_mret = 1'b0;
    csr_ctrl_o.mtval        = '0;

    ctrl_busy_o      = 1'b1;
    controller_run_o = 1'b0;
    perf_jump_o      = 1'b0;
    perf_tbranch_o   = 1'b0;

    halt_if   = 1'b0;
    retain_id = 1'b0;
    flush_id  = 1'b0;

    case (state_q)
      RESET: begin
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = BOOT_SET;
      end

      BOOT_SET: begin
        // boot address into the fetch pc
        pc_ctrl_o.pc_set = 1'b1;
        state_d          = FIRST_FETCH;
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        if (irq_i.wake) begin
          state_d = FIRST_FETCH;
        end else begin
          // clock may stay gated
          ctrl_busy_o = 1'b0;
        end
      end

      FIRST_FETCH: begin
        // wait for the IF miss to resolve
        if (!stall) begin
          state_d = DECODE;
        end
        // irq entry lets the ID instruction complete
        if (irq_i.handle) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      DECODE: begin
        controller_run_o = 1'b1;
        // mux is cheap to set early, pc_set decides
        pc_ctrl_o.pc_mux = PC_JUMP;

        // keep the instruction in ID for the FLUSH state
        if (special_i.special_req) begin
          retain_id = 1'b1;
          state_d   = FLUSH;
        end

        if ((branch_set_i || jump_set_i) && instr_valid_i && !special_i.branch_block) begin
          pc_ctrl_o.pc_set = 1'b1;
          perf_tbranch_o   = branch_set_i;
          perf_jump_o      = jump_set_i;
        end

        // irq waits until the current instruction is done
        if (irq_i.handle && stall) begin
          halt_if = 1'b1;
        end

        if (!stall && !special_i.special_req && irq_i.handle) begin
          state_d = IRQ_TAKEN;
          halt_if = 1'b1;
        end
      end

      IRQ_TAKEN: begin
        pc_ctrl_o.pc_mux     = PC_EXC;
        pc_ctrl_o.exc_pc_mux = EXC_PC_IRQ;
        if (irq_i.handle) begin
          pc_ctrl_o.pc_set      = 1'b1;
          csr_ctrl_o.save_if    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          exc_cause_o           = irq_i.cause;
          if (irq_i.nmi) begin
            nmi_mode_d = 1'b1;
          end
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (special_i.exc_req) begin
          // trap: epc from ID, cause and mtval from exc_detect
          pc_ctrl_o.pc_set      = 1'b1;
          pc_ctrl_o.pc_mux      = PC_EXC;
          pc_ctrl_o.exc_pc_mux  = EXC_PC_EXC;
          csr_ctrl_o.save_id    = 1'b1;
          csr_ctrl_o.save_cause = 1'b1;
          csr_ctrl_o.mtval      = exc_i.mtval;
          exc_cause_o           = exc_i.cause;
        end else if (special_i.mret) begin
          pc_ctrl_o.pc_set        = 1'b1;
          pc_ctrl_o.pc_mux        = PC_ERET;
          csr_ctrl_o.restore_mret = 1'b1;
          // leaving the nmi handler
          nmi_mode_d              = 1'b0;
        end else if (special_i.wfi) begin
          state_d = WAIT_SLEEP;
        end else if (special_i.csr_flush && irq_i.handle) begin
          // csr write may have just enabled an interrupt
          state_d = IRQ_TAKEN;
        end
      end

      default: begin
        state_d = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // stall control
  //////////////////////////////////////////////////////////////////////

  assign id_in_ready_o = ~stall & ~halt_if & ~retain_id;

  // retain_id keeps valid set unless ID is flushed as well
  assign instr_valid_clear_o = ~(stall | retain_id) | flush_id;

  assign flush_id_o = flush_id;
  assign in_flush_o = (state_q == FLUSH);
  assign nmi_mode_o = nmi_mode_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= RESET;
      nmi_mode_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      nmi_mode_q <= nmi_mode_d;
    end
  end

endmodule

// ==== design/core_ctrl.sv ====
/*
  core control unit top level
  - exception detection, interrupt selection and controller FSM
  - connects the three blocks and the core-side ports
*/
module core_ctrl import ctrl_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  dec_flags_t  dec_i,
  input  instr_info_t instr_i,
  input  priv_lvl_e   priv_i,
  input  logic        mstatus_tw_i,
  input  logic        mstatus_mie_i,
  input  irqs_t       irqs_i,
  input  logic        irq_nm_i,
  input  logic        branch_set_i,
  input  logic        jump_set_i,
  input  logic        stall_id_i,
  output pc_ctrl_t    pc_ctrl_o,
  output exc_cause_t  exc_cause_o,
  output csr_ctrl_t   csr_ctrl_o,
  output logic        id_in_ready_o,
  output logic        instr_valid_clear_o,
  output logic        flush_id_o,
  output logic        ctrl_busy_o,
  output logic        controller_run_o,
  output logic        nmi_mode_o,
  output logic        perf_jump_o,
  output logic        perf_tbranch_o
);

  logic      in_flush;
  special_t  special;
  exc_info_t exc_info;
  irq_req_t  irq_req;

  // decoder flags to special requests and cause
  exc_detect u_exc_detect (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .dec_i        (dec_i),
    .instr_i      (instr_i),
    .priv_i       (priv_i),
    .mstatus_tw_i (mstatus_tw_i),
    .in_flush_i   (in_flush),
    .special_o    (special),
    .exc_o        (exc_info)
  );

  // nmi mode fed back from the fsm
  irq_select u_irq_select (
    .irqs_i        (irqs_i),
    .irq_nm_i      (irq_nm_i),
    .mstatus_mie_i (mstatus_mie_i),
    .nmi_mode_i    (nmi_mode_o),
    .irq_o         (irq_req)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .special_i           (special),
    .exc_i               (exc_info),
    .irq_i               (irq_req),
    .instr_valid_i       (instr_i.valid),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .stall_id_i          (stall_id_i),
    .in_flush_o          (in_flush),
    .pc_ctrl_o           (pc_ctrl_o),
    .exc_cause_o         (exc_cause_o),
    .csr_ctrl_o          (csr_ctrl_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .controller_run_o    (controller_run_o),
    .nmi_mode_o          (nmi_mode_o),
    .perf_jump_o         (perf_jump_o),
    .perf_tbranch_o      (perf_tbranch_o)
  );

endmodule

// ==== include/tb_vectors.svh ====
/*
  stimulus and expected values for the core control testbench
  - entry kinds, mtval kinds and interrupt line patterns
  - one table row per test, applied in order
*/
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// entry kinds
localparam logic [1:0] K_SYNC = 2'd0;
localparam logic [1:0] K_IRQ  = 2'd1;
localparam logic [1:0] K_WFI  = 2'd2;

// how the expected mtval is formed
localparam logic [1:0] MT_PC    = 2'd0;
localparam logic [1:0] MT_PC2   = 2'd1;
localparam logic [1:0] MT_INSTR = 2'd2;
localparam logic [1:0] MT_ZERO  = 2'd3;

// irq lines: software 17, timer 16, external 15, fast 14:0
localparam logic [17:0] IRQ_NONE = 18'h00000;
localparam logic [17:0] IRQ_SW   = 18'h20000;
localparam logic [17:0] IRQ_TM   = 18'h10000;
localparam logic [17:0] IRQ_EX   = 18'h08000;
localparam logic [17:0] IRQ_F3_14 = 18'h04008;

// dec bits: illegal ecall mret wfi ebrk csr_flush
typedef struct packed {
  logic [1:0] kind;
  dec_flags_t dec;
  logic       fetch_err;
  logic       plus2;
  logic       compressed;
  priv_lvl_e  priv;
  logic       tw;
  logic       mie;
  irqs_t      irqs;
  logic       nmi;
  logic       exp_set;
  pc_sel_e    exp_mux;
  exc_cause_t exp_cause;
  logic [1:0] mtval_kind;
  logic       exp_nmi_mode;
} vec_t;

localparam int NUM_VECS = 19;

localparam vec_t VECS [NUM_VECS] = '{
  // synchronous exceptions
  '{K_SYNC, 6'b000000, 1'b1, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h01, MT_PC, 1'b0},
  // fetch fault beats illegal
  '{K_SYNC, 6'b100000, 1'b1, 1'b1, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h01, MT_PC2, 1'b0},
  '{K_SYNC, 6'b100000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0},
  '{K_SYNC, 6'b100000, 1'b0, 1'b0, 1'b1, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0},
  '{K_SYNC, 6'b010000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h0B, MT_ZERO, 1'b0},
  '{K_SYNC, 6'b010000, 1'b0, 1'b0, 1'b0, PRIV_LVL_U, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h08, MT_ZERO, 1'b0},
  '{K_SYNC, 6'b000010, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h03, MT_ZERO, 1'b0},
  // mret and trapped wfi outside M-mode
  '{K_SYNC, 6'b001000, 1'b0, 1'b0, 1'b0, PRIV_LVL_U, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0},
  '{K_SYNC, 6'b000100, 1'b0, 1'b0, 1'b0, PRIV_LVL_U, 1'b1, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h02, MT_INSTR, 1'b0},
  '{K_SYNC, 6'b010010, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_EXC, 6'h0B, MT_ZERO, 1'b0},
  '{K_SYNC, 6'b001000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_ERET, 6'h00, MT_ZERO, 1'b0},
  // interrupts by priority
  '{K_IRQ, 6'b000000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b1, IRQ_TM, 1'b0,
    1'b1, PC_EXC, 6'h27, MT_ZERO, 1'b0},
  '{K_IRQ, 6'b000000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b1, IRQ_SW | IRQ_TM, 1'b0,
    1'b1, PC_EXC, 6'h23, MT_ZERO, 1'b0},
  '{K_IRQ, 6'b000000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b1, IRQ_EX | IRQ_SW, 1'b0,
    1'b1, PC_EXC, 6'h2B, MT_ZERO, 1'b0},
  '{K_IRQ, 6'b000000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b1, IRQ_F3_14 | IRQ_EX, 1'b0,
    1'b1, PC_EXC, 6'h3E, MT_ZERO, 1'b0},
  // nmi, blocked nesting, then mret leaves nmi mode
  '{K_IRQ, 6'b000000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_TM, 1'b1,
    1'b1, PC_EXC, 6'h3F, MT_ZERO, 1'b1},
  '{K_IRQ, 6'b000000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b1, IRQ_TM, 1'b0,
    1'b0, PC_BOOT, 6'h00, MT_ZERO, 1'b1},
  '{K_SYNC, 6'b001000, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_NONE, 1'b0,
    1'b1, PC_ERET, 6'h00, MT_ZERO, 1'b0},
  // wfi, wake on timer, entry once mie is set
  '{K_WFI, 6'b000100, 1'b0, 1'b0, 1'b0, PRIV_LVL_M, 1'b0, 1'b0, IRQ_TM, 1'b0,
    1'b1, PC_EXC, 6'h27, MT_ZERO, 1'b0}
};

`endif

// ==== verification/tb_core_ctrl.sv ====
/*
  testbench of the core control unit
  - clock, reset and watchdog
  - boot, table driven exception, interrupt and wfi tests
  - branch, jump and stall tests, per-test lines and summary
*/
module tb_core_ctrl import ctrl_pkg::*; ();

  `include "tb_vectors.svh"

  localparam int WATCHDOG_CYCLES = (NUM_VECS + 8) * 40;

  logic        clk_i;
  logic        rst_ni;
  dec_flags_t  dec;
  instr_info_t instr;
  priv_lvl_e   priv;
  logic        tw;
  logic        mie;
  irqs_t       irqs;
  logic        irq_nm;
  logic        branch_set;
  logic        jump_set;
  logic        stall;

  pc_ctrl_t   pc_ctrl;
  exc_cause_t exc_cause;
  csr_ctrl_t  csr_ctrl;
  logic       id_in_ready;
  logic       instr_valid_clear;
  logic       flush_id;
  logic       ctrl_busy;
  logic       controller_run;
  logic       nmi_mode;
  logic       perf_jump;
  logic       perf_tbranch;

  int errors;
  int checks;
  int failed_tests;
  int num_tests;

  core_ctrl DUT (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .dec_i               (dec),
    .instr_i             (instr),
    .priv_i              (priv),
    .mstatus_tw_i        (tw),
    .mstatus_mie_i       (mie),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .stall_id_i          (stall),
    .pc_ctrl_o           (pc_ctrl),
    .exc_cause_o         (exc_cause),
    .csr_ctrl_o          (csr_ctrl),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear),
    .flush_id_o          (flush_id),
    .ctrl_busy_o         (ctrl_busy),
    .controller_run_o    (controller_run),
    .nmi_mode_o          (nmi_mode),
    .perf_jump_o         (perf_jump),
    .perf_tbranch_o      (perf_tbranch)
  );

  always #10 clk_i = ~clk_i;

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    num_tests++;
    if (errors != errs_at_start) begin
      failed_tests++;
      $display("%s: FAILED", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // all inputs back to an idle M-mode core
  task automatic idle_inputs();
    dec        <= '0;
    instr      <= '0;
    priv       <= PRIV_LVL_M;
    tw         <= 1'b0;
    mie        <= 1'b0;
    irqs       <= '0;
    irq_nm     <= 1'b0;
    branch_set <= 1'b0;
    jump_set   <= 1'b0;
    stall      <= 1'b0;
  endtask

  // mtval as the trap rules define it
  function automatic word_t expected_mtval(vec_t v, instr_info_t ii);
    case (v.mtval_kind)
      MT_PC:    return ii.pc;
      MT_PC2:   return ii.pc + 32'd2;
      MT_INSTR: return v.compressed ? {16'h0000, ii.instr_c} : ii.instr;
      default:  return '0;
    endcase
  endfunction

  task automatic drive_vec(input vec_t v, output instr_info_t ii);
    logic [31:0] r;
    ii.valid           = (v.kind != K_IRQ);
    ii.instr           = $urandom;
    r                  = $urandom;
    ii.instr_c         = r[15:0];
    ii.is_compressed   = v.compressed;
    ii.fetch_err       = v.fetch_err;
    ii.fetch_err_plus2 = v.plus2;
    ii.pc              = $urandom & 32'hFFFF_FFFE;
    dec   <= v.dec;
    instr <= ii;
    priv  <= v.priv;
    tw    <= v.tw;
    mie   <= v.mie;
    if (v.kind != K_WFI) begin
      irqs   <= v.irqs;
      irq_nm <= v.nmi;
    end
  endtask

  // cycle after DECODE, either FLUSH or IRQ_TAKEN
  task automatic check_entry(input vec_t v, input instr_info_t ii);
    check_val("pc_set", pc_ctrl.pc_set, v.exp_set);
    if (v.exp_set && v.exp_mux == PC_ERET) begin
      check_val("pc_mux", pc_ctrl.pc_mux, PC_ERET);
      check_val("restore_mret", csr_ctrl.restore_mret, 1'b1);
    end else if (v.exp_set) begin
      check_val("pc_mux", pc_ctrl.pc_mux, PC_EXC);
      check_val("exc_cause", exc_cause, v.exp_cause);
      check_val("save_cause", csr_ctrl.save_cause, 1'b1);
      if (v.kind == K_SYNC) begin
        check_val("exc_pc_mux", pc_ctrl.exc_pc_mux, EXC_PC_EXC);
        check_val("save_id", csr_ctrl.save_id, 1'b1);
        check_val("mtval", csr_ctrl.mtval, expected_mtval(v, ii));
      end else begin
        check_val("exc_pc_mux", pc_ctrl.exc_pc_mux, EXC_PC_IRQ);
        check_val("save_if", csr_ctrl.save_if, 1'b1);
      end
    end
  endtask

  task automatic wfi_sleep_wake(input vec_t v);
    int gap;
    int waited;
    check_val("ctrl_busy", ctrl_busy, 1'b0);
    gap = 1 + ($urandom % 4);
    repeat (gap) begin
      @(negedge clk_i);
      check_val("ctrl_busy", ctrl_busy, 1'b0);
    end
    // wake without mie, entry only follows once mie is set
    @(posedge clk_i);
    irqs <= v.irqs;
    waited = 0;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!ctrl_busy && waited < 20);
    if (!ctrl_busy) begin
      errors++;
      $display("ctrl_busy_o did not rise after the wake-up line was raised");
    end
    @(posedge clk_i);
    @(posedge clk_i);
    mie <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    check_val("pc_set", pc_ctrl.pc_set, 1'b1);
    check_val("exc_cause", exc_cause, v.exp_cause);
    check_val("save_if", csr_ctrl.save_if, 1'b1);
    @(posedge clk_i);
    idle_inputs();
  endtask

  task automatic branch_test(input logic is_jump);
    @(posedge clk_i);
    instr.valid <= 1'b1;
    branch_set  <= ~is_jump;
    jump_set    <= is_jump;
    @(negedge clk_i);
    check_val("pc_set", pc_ctrl.pc_set, 1'b1);
    check_val("pc_mux", pc_ctrl.pc_mux, PC_JUMP);
    check_val("perf_tbranch", perf_tbranch, !is_jump);
    check_val("perf_jump", perf_jump, is_jump);
    @(posedge clk_i);
    idle_inputs();
    @(negedge clk_i);
  endtask

  task automatic stall_test();
    @(posedge clk_i);
    stall <= 1'b1;
    irqs  <= IRQ_TM;
    mie   <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_val("id_in_ready", id_in_ready, 1'b0);
      // instruction stays in ID while stalled
      check_val("instr_valid_clear", instr_valid_clear, 1'b0);
      check_val("pc_set", pc_ctrl.pc_set, 1'b0);
    end
    @(posedge clk_i);
    stall <= 1'b0;
    @(posedge clk_i);
    @(negedge clk_i);
    check_val("pc_set", pc_ctrl.pc_set, 1'b1);
    check_val("exc_cause", exc_cause, 6'h27);
    check_val("save_if", csr_ctrl.save_if, 1'b1);
    @(posedge clk_i);
    idle_inputs();
    @(negedge clk_i);
  endtask

  ////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    instr_info_t ii;
    int          start;
    void'($urandom(32'heef4));
    errors       = 0;
    checks       = 0;
    failed_tests = 0;
    num_tests    = 0;
    clk_i        = 1'b0;
    rst_ni       = 1'b0;
    idle_inputs();

    repeat (5) @(posedge clk_i);
    start = errors;
    @(negedge clk_i);
    check_val("nmi_mode", nmi_mode, 1'b0);
    check_val("save_cause", csr_ctrl.save_cause, 1'b0);
    @(posedge clk_i);
    rst_ni <= 1'b1;
    // RESET then BOOT_SET, both set the boot pc
    repeat (2) begin
      @(negedge clk_i);
      check_val("pc_set", pc_ctrl.pc_set, 1'b1);
      check_val("pc_mux", pc_ctrl.pc_mux, PC_BOOT);
      check_val("controller_run", controller_run, 1'b0);
    end
    @(negedge clk_i);
    check_val("pc_set", pc_ctrl.pc_set, 1'b0);
    @(negedge clk_i);
    check_val("controller_run", controller_run, 1'b1);
    report_test("boot", start);

    for (int i = 0; i < NUM_VECS; i++) begin
      start = errors;
      @(posedge clk_i);
      drive_vec(VECS[i], ii);
      @(posedge clk_i);
      @(negedge clk_i);
      if (VECS[i].kind == K_WFI) begin
        check_val("pc_set", pc_ctrl.pc_set, 1'b0);
      end else begin
        check_entry(VECS[i], ii);
      end
      // traps, mret and wfi pass through FLUSH, interrupts do not
      check_val("flush_id", flush_id, VECS[i].kind != K_IRQ);
      @(posedge clk_i);
      idle_inputs();
      @(negedge clk_i);
      if (VECS[i].kind == K_WFI) begin
        wfi_sleep_wake(VECS[i]);
        @(negedge clk_i);
      end
      check_val("nmi_mode", nmi_mode, VECS[i].exp_nmi_mode);
      report_test($sformatf("vector %0d", i), start);
    end

    start = errors;
    branch_test(1'b0);
    report_test("branch", start);
    start = errors;
    branch_test(1'b1);
    report_test("jump", start);
    start = errors;
    stall_test();
    report_test("stall", start);

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             num_tests, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // watchdog scaled to the table length
  initial begin
    #(WATCHDOG_CYCLES * 20);
    $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test failed");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+include
design/ctrl_pkg.sv
design/exc_detect.sv
design/irq_select.sv
design/ctrl_fsm.sv
design/core_ctrl.sv
verification/tb_core_ctrl.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only --timing
TOP       ?= tb_core_ctrl
RTL_TOP   ?= core_ctrl
FLIST     ?= flist.f
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)
